//--- compile.f
+incdir+rtl
+incdir+dv
rtl/control_pkg.sv
rtl/rtype_decoder.sv
rtl/itype_decoder.sv
rtl/control_select.sv
rtl/control_unit.sv
dv/control_unit_tb.sv

//--- run.sh
#!/bin/sh
# build and run the control unit testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing \
    -f compile.f \
    --top-module control_unit_tb \
    -o control_unit_sim

./obj_dir/control_unit_sim | tee sim.log

if grep -q "Verification passed" sim.log; then
    echo "simulation PASSED"
else
    echo "simulation FAILED"
    exit 1
fi

//--- dv/control_ref.svh
`ifndef CONTROL_REF_SVH
`define CONTROL_REF_SVH

typedef struct packed {
    logic [`ALU_CTRL_W-1:0] alu;
    logic [`REG_ADDR_W-1:0] ra1;
    logic [`REG_ADDR_W-1:0] ra2;
    logic [`DATA_W-1:0]     imm;
    logic                   br;
    logic                   we;
    logic                   mrd;
    logic                   mwr;
    logic                   m2r;
    logic                   ss;
    logic [1:0]             mul;
} ctrl_word_t;

// expected control word for one instruction, type 3 and unknown codes give the idle word
function automatic ctrl_word_t expected_control(
    input logic [1:0]             typ,
    input logic [`OPCODE_W-1:0]   op,
    input logic [`FUNC_W-1:0]     fn,
    input logic [`REG_ADDR_W-1:0] rs,
    input logic [`REG_ADDR_W-1:0] rt,
    input logic [`SHAMT_W-1:0]    shamt,
    input logic [`DATA_W-1:0]     imm
);
    ctrl_word_t w;
    w     = '0;
    w.alu = ALU_NOP;
    if (typ == TYPE_J) begin
        w.alu = ALU_JUMP;
        w.ra1 = rs;
    end else if (typ == TYPE_R) begin
        case (fn)
            FN_ADD:  w.alu = ALU_ADD;
            FN_ADDU: w.alu = ALU_ADDU;
            FN_SUB:  w.alu = ALU_SUB;
            FN_SUBU: w.alu = ALU_SUBU;
            FN_MUL:  w.alu = ALU_MUL;
            FN_AND:  w.alu = ALU_AND;
            FN_OR:   w.alu = ALU_OR;
            FN_XOR:  w.alu = ALU_XOR;
            FN_NOT:  w.alu = ALU_NOT;
            FN_SLL:  w.alu = ALU_SLL;
            FN_SRL:  w.alu = ALU_SRL;
            FN_SRA:  w.alu = ALU_SRA;
            FN_SLA:  w.alu = ALU_SLA;
            FN_SLT:  w.alu = ALU_SLT;
            FN_SEQ:  w.alu = ALU_SEQ;
            default: w.alu = ALU_NOP;
        endcase
        if (w.alu != ALU_NOP) begin              // every defined func writes back
            w.we  = 1'b1;
            w.ra1 = rs;
            w.ra2 = rt;
        end
        if (fn inside {FN_NOT, FN_SLL, FN_SRL, FN_SRA, FN_SLA}) begin
            w.ra2 = '0;
        end
        if (fn inside {FN_SLL, FN_SRL, FN_SRA, FN_SLA}) begin
            w.ss  = 1'b1;
            w.imm = 32'(shamt);
        end
        if (fn == FN_MUL) begin
            w.mul = MUL_HILO;
        end
    end else if (typ == TYPE_I) begin
        case (op)
            OP_ADDI:  w.alu = ALU_ADD;
            OP_ADDIU: w.alu = ALU_ADDU;
            OP_ANDI:  w.alu = ALU_AND;
            OP_ORI:   w.alu = ALU_OR;
            OP_XORI:  w.alu = ALU_XOR;
            OP_SLTI:  w.alu = ALU_SLT;
            OP_BEQ:   w.alu = ALU_SEQ;
            OP_BNE:   w.alu = ALU_SNE;
            OP_BGE:   w.alu = ALU_SGE;
            OP_BLT:   w.alu = ALU_SLT;
            OP_BLE:   w.alu = ALU_SLE;
            OP_BLEU:  w.alu = ALU_SLEU;
            OP_BGTU:  w.alu = ALU_SGTU;
            OP_BGT:   w.alu = ALU_SGT;
            OP_MADD:  w.alu = ALU_MUL;
            OP_MADDU: w.alu = ALU_MADDU;
            OP_LW, OP_SW, OP_LUI: w.alu = ALU_ADD;
            default:  w.alu = ALU_NOP;
        endcase
        if (op inside {OP_ADDI, OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI}) begin
            w.ra1 = rs;
            w.ss  = 1'b1;
            w.we  = 1'b1;
            w.imm = imm;
        end
        if (op inside {OP_BEQ, OP_BNE, OP_BGE, OP_BLT, OP_BLE, OP_BLEU, OP_BGTU, OP_BGT}) begin
            w.ra1 = rs;
            w.ra2 = rt;
            w.br  = 1'b1;
        end
        if (op == OP_LW || op == OP_SW) begin
            w.ra1 = rs;
            w.ra2 = rt;
            w.ss  = 1'b1;
            w.mrd = 1'b1;                        // sw reads memory as well
            w.imm = imm;
            w.we  = (op == OP_LW);
            w.m2r = (op == OP_LW);
            w.mwr = (op == OP_SW);
        end
        if (op == OP_LUI) begin
            w.ra2 = rt;
            w.ss  = 1'b1;
            w.we  = 1'b1;
            w.mrd = 1'b1;
            w.imm = {imm[15:0], 16'h0000};
        end
        if (op == OP_MADD || op == OP_MADDU) begin
            w.ra1 = rs;
            w.ra2 = rt;
            w.we  = 1'b1;
            w.mul = MUL_ACC;
        end
    end
    return w;
endfunction

`endif

//--- dv/control_unit_tb.sv
`timescale 1ns/1ns
`include "control_defines.svh"

module control_unit_tb
    import control_pkg::*;
();

    localparam int NUM_INSTR    = 2000;
    localparam int CLK_PERIOD   = 100;
    localparam int RESET_CYCLES = 10;
    localparam int WATCHDOG_NS  = NUM_INSTR * CLK_PERIOD * 2 + RESET_CYCLES * CLK_PERIOD;

    localparam logic [`FUNC_W-1:0] FUNC_TABLE [15] = '{
        FN_SLL, FN_SRL, FN_SRA, FN_SLA, FN_ADD, FN_ADDU, FN_SUB, FN_SUBU,
        FN_AND, FN_OR, FN_XOR, FN_NOT, FN_MUL, FN_SLT, FN_SEQ
    };
    localparam logic [`OPCODE_W-1:0] OPCODE_TABLE [19] = '{
        OP_BEQ, OP_BNE, OP_ADDI, OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI, OP_BGE,
        OP_BLT, OP_BLE, OP_BLEU, OP_BGTU, OP_BGT, OP_MADD, OP_MADDU, OP_LW, OP_SW
    };

    logic                   clk = 1'b0;
    logic                   arst_n;
    logic                   instr_valid;
    instr_type_e            instr_type;
    logic [`OPCODE_W-1:0]   opcode;
    logic [`FUNC_W-1:0]     func;
    logic [`REG_ADDR_W-1:0] rs;
    logic [`REG_ADDR_W-1:0] rt;
    logic [`SHAMT_W-1:0]    shamt;
    logic [`DATA_W-1:0]     imm;
    logic                   ctrl_valid;
    alu_op_e                alu_ctrl;
    logic [`REG_ADDR_W-1:0] read_address_1;
    logic [`REG_ADDR_W-1:0] read_address_2;
    logic [`DATA_W-1:0]     immediate_value;
    logic                   branch_yes;
    logic                   write_enable;
    logic                   mem_read;
    logic                   mem_write;
    logic                   mem_to_reg;
    logic                   second_select;
    mul_mode_e              mul;

    `include "control_ref.svh"

    integer     seed;
    int         accepted;
    logic       exp_valid;                       // instruction taken at the last rising edge
    logic       checking;
    ctrl_word_t expected_q[$];
    ctrl_word_t last_exp;

    control_unit control_unit_i (.*);

    always #(CLK_PERIOD / 2) clk = ~clk;

    task automatic stop_run(input string reason);
        $display("%s", reason);
        $display("Verification failed");
        $fatal(1, "run stopped at %0t", $time);
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            stop_run($sformatf("mismatch %s: got 0x%0h, expected 0x%0h", name, actual, expected));
        end
    endtask

    task automatic compare_outputs(input ctrl_word_t e);
        check_value("alu_ctrl", 32'(alu_ctrl), 32'(e.alu));
        check_value("read_address_1", 32'(read_address_1), 32'(e.ra1));
        check_value("read_address_2", 32'(read_address_2), 32'(e.ra2));
        check_value("immediate_value", immediate_value, e.imm);
        check_value("branch_yes", 32'(branch_yes), 32'(e.br));
        check_value("write_enable", 32'(write_enable), 32'(e.we));
        check_value("mem_read", 32'(mem_read), 32'(e.mrd));
        check_value("mem_write", 32'(mem_write), 32'(e.mwr));
        check_value("mem_to_reg", 32'(mem_to_reg), 32'(e.m2r));
        check_value("second_select", 32'(second_select), 32'(e.ss));
        check_value("mul", 32'(mul), 32'(e.mul));
    endtask

    function automatic logic [31:0] rand_word();
        return $random(seed);
    endfunction

    function automatic logic [1:0] pick_type(input logic [31:0] r);
        if (r[3:0] >= 4'd14) begin
            return r[9:8];                       // type 3 now and then
        end else begin
            return (r[9:8] == 2'd3) ? 2'd1 : r[9:8];
        end
    endfunction

    function automatic logic [`FUNC_W-1:0] pick_func(input logic [31:0] r);
        if (r[3:0] < 4'd12) begin
            return FUNC_TABLE[4'(r[31:4] % 28'd15)];
        end else begin
            return r[21:16];                     // any func, floating-point range too
        end
    endfunction

    function automatic logic [`OPCODE_W-1:0] pick_opcode(input logic [31:0] r);
        if (r[3:0] < 4'd12) begin
            return OPCODE_TABLE[5'(r[31:4] % 28'd19)];
        end else begin
            return r[21:16];
        end
    endfunction

    // outputs are stable at the falling edge
    always @(negedge clk) begin
        if (checking) begin
            if (ctrl_valid !== exp_valid) begin
                if (ctrl_valid === 1'b1) begin
                    stop_run("ctrl_valid is high although no instruction was accepted");
                end else begin
                    stop_run("ctrl_valid stayed low one cycle after an accepted instruction");
                end
            end else if (ctrl_valid === 1'b1 && expected_q.size() == 0) begin
                stop_run("ctrl_valid is high while no result is expected");
            end else begin
                if (ctrl_valid === 1'b1) begin
                    last_exp = expected_q.pop_front();
                end
                compare_outputs(last_exp);       // idle cycles hold the last word
            end
        end
    end

    initial begin
        logic [31:0] r;
        seed        = 32'h278f;
        accepted    = 0;
        exp_valid   = 1'b0;
        checking    = 1'b0;
        arst_n      = 1'b0;
        instr_valid = 1'b0;
        instr_type  = TYPE_R;
        opcode      = '0;
        func        = '0;
        rs          = '0;
        rt          = '0;
        shamt       = '0;
        imm         = '0;
        // reset state matches the do-nothing decode
        last_exp    = expected_control(2'd3, '0, '0, '0, '0, '0, '0);

        @(posedge clk);
        checking = 1'b1;
        repeat (RESET_CYCLES - 1) @(posedge clk);
        arst_n <= 1'b1;

        while (accepted < NUM_INSTR) begin
            @(posedge clk);
            exp_valid = instr_valid;
            if (instr_valid) begin
                expected_q.push_back(expected_control(instr_type, opcode, func, rs, rt,
                                                      shamt, imm));
                accepted++;
            end
            if (accepted < NUM_INSTR) begin
                r = rand_word();
                instr_valid <= (r[7:0] < 8'd205);   // about 80 % busy
                instr_type  <= instr_type_e'(pick_type(rand_word()));
                opcode      <= pick_opcode(rand_word());
                func        <= pick_func(rand_word());
                r = rand_word();
                rs          <= r[4:0];
                rt          <= r[9:5];
                shamt       <= r[14:10];
                imm         <= rand_word();
            end else begin
                instr_valid <= 1'b0;
            end
        end

        repeat (2) begin
            @(posedge clk);
            exp_valid = instr_valid;
        end
        @(posedge clk);
        if (expected_q.size() == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            stop_run("results were still pending at the end of the run");
        end
    end

    initial begin
        #(WATCHDOG_NS);
        stop_run("watchdog expired before all instructions were checked");
    end

endmodule

//--- rtl/control_unit.sv
`timescale 1ns/1ns
`include "control_defines.svh"

module control_unit
    import control_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   instr_valid,
    input  instr_type_e            instr_type,
    input  logic [`OPCODE_W-1:0]   opcode,
    input  logic [`FUNC_W-1:0]     func,
    input  logic [`REG_ADDR_W-1:0] rs,
    input  logic [`REG_ADDR_W-1:0] rt,
    input  logic [`SHAMT_W-1:0]    shamt,
    input  logic [`DATA_W-1:0]     imm,
    output logic                   ctrl_valid,
    output alu_op_e                alu_ctrl,
    output logic [`REG_ADDR_W-1:0] read_address_1,
    output logic [`REG_ADDR_W-1:0] read_address_2,
    output logic [`DATA_W-1:0]     immediate_value,
    output logic                   branch_yes,
    output logic                   write_enable,
    output logic                   mem_read,
    output logic                   mem_write,
    output logic                   mem_to_reg,
    output logic                   second_select,
    output mul_mode_e              mul
);

    // r-type decode
    alu_op_e                r_alu_ctrl;
    logic [`REG_ADDR_W-1:0] r_read_address_1;
    logic [`REG_ADDR_W-1:0] r_read_address_2;
    logic [`DATA_W-1:0]     r_immediate_value;
    logic                   r_branch_yes, r_write_enable, r_mem_read, r_mem_write;
    logic                   r_mem_to_reg, r_second_select;
    mul_mode_e              r_mul;

    // i-type decode
    alu_op_e                i_alu_ctrl;
    logic [`REG_ADDR_W-1:0] i_read_address_1;
    logic [`REG_ADDR_W-1:0] i_read_address_2;
    logic [`DATA_W-1:0]     i_immediate_value;
    logic                   i_branch_yes, i_write_enable, i_mem_read, i_mem_write;
    logic                   i_mem_to_reg, i_second_select;
    mul_mode_e              i_mul;

    // both decoders see every instruction, the select stage picks by type
    rtype_decoder rtype_decoder_i (
        .*
    );

    itype_decoder itype_decoder_i (
        .*
    );

    control_select control_select_i (
        .*
    );

endmodule

//--- rtl/control_select.sv
`timescale 1ns/1ns
`include "control_defines.svh"

module control_select
    import control_pkg::*;
(
    input  logic                   clk,
    input  logic                   arst_n,
    input  logic                   instr_valid,
    input  instr_type_e            instr_type,
    input  logic [`REG_ADDR_W-1:0] rs,
    input  alu_op_e                r_alu_ctrl,
    input  logic [`REG_ADDR_W-1:0] r_read_address_1,
    input  logic [`REG_ADDR_W-1:0] r_read_address_2,
    input  logic [`DATA_W-1:0]     r_immediate_value,
    input  logic                   r_branch_yes,
    input  logic                   r_write_enable,
    input  logic                   r_mem_read,
    input  logic                   r_mem_write,
    input  logic                   r_mem_to_reg,
    input  logic                   r_second_select,
    input  mul_mode_e              r_mul,
    input  alu_op_e                i_alu_ctrl,
    input  logic [`REG_ADDR_W-1:0] i_read_address_1,
    input  logic [`REG_ADDR_W-1:0] i_read_address_2,
    input  logic [`DATA_W-1:0]     i_immediate_value,
    input  logic                   i_branch_yes,
    input  logic                   i_write_enable,
    input  logic                   i_mem_read,
    input  logic                   i_mem_write,
    input  logic                   i_mem_to_reg,
    input  logic                   i_second_select,
    input  mul_mode_e              i_mul,
    output logic                   ctrl_valid,
    output alu_op_e                alu_ctrl,
    output logic [`REG_ADDR_W-1:0] read_address_1,
    output logic [`REG_ADDR_W-1:0] read_address_2,
    output logic [`DATA_W-1:0]     immediate_value,
    output logic                   branch_yes,
    output logic                   write_enable,
    output logic                   mem_read,
    output logic                   mem_write,
    output logic                   mem_to_reg,
    output logic                   second_select,
    output mul_mode_e              mul
);

    alu_op_e                sel_alu_ctrl;
    logic [`REG_ADDR_W-1:0] sel_read_address_1;
    logic [`REG_ADDR_W-1:0] sel_read_address_2;
    logic [`DATA_W-1:0]     sel_immediate_value;
    logic [5:0]             sel_bits;                // {branch, we, mrd, mwr, m2r, ss}
    mul_mode_e              sel_mul;

    always_comb begin
        sel_alu_ctrl        = ALU_NOP;               // type 3 falls through to this
        sel_read_address_1  = '0;
        sel_read_address_2  = '0;
        sel_immediate_value = '0;
        sel_bits            = '0;
        sel_mul             = MUL_NONE;
        case (instr_type)
            TYPE_R: begin
                sel_alu_ctrl        = r_alu_ctrl;
                sel_read_address_1  = r_read_address_1;
                sel_read_address_2  = r_read_address_2;
                sel_immediate_value = r_immediate_value;
                sel_bits            = {r_branch_yes, r_write_enable, r_mem_read, r_mem_write,
                                       r_mem_to_reg, r_second_select};
                sel_mul             = r_mul;
            end
            TYPE_I: begin
                sel_alu_ctrl        = i_alu_ctrl;
                sel_read_address_1  = i_read_address_1;
                sel_read_address_2  = i_read_address_2;
                sel_immediate_value = i_immediate_value;
                sel_bits            = {i_branch_yes, i_write_enable, i_mem_read, i_mem_write,
                                       i_mem_to_reg, i_second_select};
                sel_mul             = i_mul;
            end
            TYPE_J: begin
                sel_alu_ctrl       = ALU_JUMP;       // jump target comes through rs
                sel_read_address_1 = rs;
            end
            default: begin
                sel_alu_ctrl = ALU_NOP;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ctrl_valid      <= 1'b0;
            alu_ctrl        <= ALU_NOP;
            read_address_1  <= '0;
            read_address_2  <= '0;
            immediate_value <= '0;
            branch_yes      <= 1'b0;
            write_enable    <= 1'b0;
            mem_read        <= 1'b0;
            mem_write       <= 1'b0;
            mem_to_reg      <= 1'b0;
            second_select   <= 1'b0;
            mul             <= MUL_NONE;
        end else begin
            ctrl_valid <= instr_valid;
            if (instr_valid) begin                   // outputs hold when idle
                alu_ctrl        <= sel_alu_ctrl;
                read_address_1  <= sel_read_address_1;
                read_address_2  <= sel_read_address_2;
                immediate_value <= sel_immediate_value;
                branch_yes      <= sel_bits[5];
                write_enable    <= sel_bits[4];
                mem_read        <= sel_bits[3];
                mem_write       <= sel_bits[2];
                mem_to_reg      <= sel_bits[1];
                second_select   <= sel_bits[0];
                mul             <= sel_mul;
            end
        end
    end

endmodule

//--- rtl/itype_decoder.sv
`timescale 1ns/1ns
`include "control_defines.svh"

module itype_decoder
    import control_pkg::*;
(
    input  logic [`OPCODE_W-1:0]   opcode,
    input  logic [`REG_ADDR_W-1:0] rs,
    input  logic [`REG_ADDR_W-1:0] rt,
    input  logic [`DATA_W-1:0]     imm,
    output alu_op_e                i_alu_ctrl,
    output logic [`REG_ADDR_W-1:0] i_read_address_1,
    output logic [`REG_ADDR_W-1:0] i_read_address_2,
    output logic [`DATA_W-1:0]     i_immediate_value,
    output logic                   i_branch_yes,
    output logic                   i_write_enable,
    output logic                   i_mem_read,
    output logic                   i_mem_write,
    output logic                   i_mem_to_reg,
    output logic                   i_second_select,
    output mul_mode_e              i_mul
);

    always_comb begin
        i_alu_ctrl        = ALU_NOP;
        i_read_address_1  = '0;
        i_read_address_2  = '0;
        i_immediate_value = '0;
        i_branch_yes      = 1'b0;
        i_write_enable    = 1'b0;
        i_mem_read        = 1'b0;
        i_mem_write       = 1'b0;
        i_mem_to_reg      = 1'b0;
        i_second_select   = 1'b0;
        i_mul             = MUL_NONE;

        // operand routing and datapath bits
        case (opcode)
            OP_ADDI, OP_ADDIU, OP_ANDI, OP_ORI, OP_XORI, OP_SLTI: begin
                i_read_address_1  = rs;
                i_second_select   = 1'b1;
                i_write_enable    = 1'b1;
                i_immediate_value = imm;
            end
            OP_BEQ, OP_BNE, OP_BGE, OP_BLT, OP_BLE, OP_BLEU, OP_BGTU, OP_BGT: begin
                i_read_address_1 = rs;               // compare rs against rt
                i_read_address_2 = rt;
                i_branch_yes     = 1'b1;
            end
            OP_LW: begin
                i_read_address_1  = rs;
                i_read_address_2  = rt;
                i_second_select   = 1'b1;            // address = rs + imm
                i_write_enable    = 1'b1;
                i_mem_read        = 1'b1;
                i_mem_to_reg      = 1'b1;
                i_immediate_value = imm;
            end
            OP_SW: begin
                i_read_address_1  = rs;
                i_read_address_2  = rt;              // store data
                i_second_select   = 1'b1;
                i_mem_read        = 1'b1;            // sw raises the read strobe too
                i_mem_write       = 1'b1;
                i_immediate_value = imm;
            end
            OP_LUI: begin
                i_read_address_2  = rt;
                i_second_select   = 1'b1;
                i_write_enable    = 1'b1;
                i_mem_read        = 1'b1;            // lui raises the read strobe too
                i_immediate_value = imm << `LUI_SHIFT;
            end
            OP_MADD, OP_MADDU: begin
                i_read_address_1 = rs;
                i_read_address_2 = rt;
                i_write_enable   = 1'b1;
                i_mul            = MUL_ACC;
            end
            default: begin
                i_mul = MUL_NONE;
            end
        endcase

        case (opcode)
            OP_ADDI:  i_alu_ctrl = ALU_ADD;
            OP_ADDIU: i_alu_ctrl = ALU_ADDU;
            OP_ANDI:  i_alu_ctrl = ALU_AND;
            OP_ORI:   i_alu_ctrl = ALU_OR;
            OP_XORI:  i_alu_ctrl = ALU_XOR;
            OP_SLTI:  i_alu_ctrl = ALU_SLT;
            OP_BEQ:   i_alu_ctrl = ALU_SEQ;
            OP_BNE:   i_alu_ctrl = ALU_SNE;
            OP_BGE:   i_alu_ctrl = ALU_SGE;
            OP_BLT:   i_alu_ctrl = ALU_SLT;
            OP_BLE:   i_alu_ctrl = ALU_SLE;
            OP_BLEU:  i_alu_ctrl = ALU_SLEU;
            OP_BGTU:  i_alu_ctrl = ALU_SGTU;
            OP_BGT:   i_alu_ctrl = ALU_SGT;
            OP_LW:    i_alu_ctrl = ALU_ADD;
            OP_SW:    i_alu_ctrl = ALU_ADD;
            OP_LUI:   i_alu_ctrl = ALU_ADD;        // r0 + shifted immediate
            OP_MADD:  i_alu_ctrl = ALU_MUL;
            OP_MADDU: i_alu_ctrl = ALU_MADDU;
            default:  i_alu_ctrl = ALU_NOP;
        endcase
    end

endmodule

//--- rtl/rtype_decoder.sv
`timescale 1ns/1ns
`include "control_defines.svh"

module rtype_decoder
    import control_pkg::*;
(
    input  logic [`FUNC_W-1:0]     func,
    input  logic [`REG_ADDR_W-1:0] rs,
    input  logic [`REG_ADDR_W-1:0] rt,
    input  logic [`SHAMT_W-1:0]    shamt,
    output alu_op_e                r_alu_ctrl,
    output logic [`REG_ADDR_W-1:0] r_read_address_1,
    output logic [`REG_ADDR_W-1:0] r_read_address_2,
    output logic [`DATA_W-1:0]     r_immediate_value,
    output logic                   r_branch_yes,
    output logic                   r_write_enable,
    output logic                   r_mem_read,
    output logic                   r_mem_write,
    output logic                   r_mem_to_reg,
    output logic                   r_second_select,
    output mul_mode_e              r_mul
);

    always_comb begin
        r_alu_ctrl        = ALU_NOP;                 // undefined func does nothing
        r_read_address_1  = '0;
        r_read_address_2  = '0;
        r_immediate_value = '0;
        r_branch_yes      = 1'b0;
        r_write_enable    = 1'b0;
        r_mem_read        = 1'b0;
        r_mem_write       = 1'b0;
        r_mem_to_reg      = 1'b0;
        r_second_select   = 1'b0;
        r_mul             = MUL_NONE;

        // operand routing
        case (func)
            FN_ADD, FN_ADDU, FN_SUB, FN_SUBU, FN_MUL,
            FN_AND, FN_OR, FN_XOR, FN_SLT, FN_SEQ: begin
                r_read_address_1 = rs;
                r_read_address_2 = rt;
                r_write_enable   = 1'b1;
            end
            FN_NOT: begin
                r_read_address_1 = rs;               // single source, port 2 reads r0
                r_write_enable   = 1'b1;
            end
            FN_SLL, FN_SRL, FN_SRA, FN_SLA: begin
                r_read_address_1  = rs;
                r_write_enable    = 1'b1;
                r_second_select   = 1'b1;            // shift amount via immediate path
                r_immediate_value = {{(`DATA_W-`SHAMT_W){1'b0}}, shamt};
            end
            default: begin
                r_write_enable = 1'b0;
            end
        endcase

        case (func)
            FN_ADD:  r_alu_ctrl = ALU_ADD;
            FN_ADDU: r_alu_ctrl = ALU_ADDU;
            FN_SUB:  r_alu_ctrl = ALU_SUB;
            FN_SUBU: r_alu_ctrl = ALU_SUBU;
            FN_MUL:  r_alu_ctrl = ALU_MUL;
            FN_AND:  r_alu_ctrl = ALU_AND;
            FN_OR:   r_alu_ctrl = ALU_OR;
            FN_XOR:  r_alu_ctrl = ALU_XOR;
            FN_NOT:  r_alu_ctrl = ALU_NOT;
            FN_SLL:  r_alu_ctrl = ALU_SLL;
            FN_SRL:  r_alu_ctrl = ALU_SRL;
            FN_SRA:  r_alu_ctrl = ALU_SRA;
            FN_SLA:  r_alu_ctrl = ALU_SLA;
            FN_SLT:  r_alu_ctrl = ALU_SLT;
            FN_SEQ:  r_alu_ctrl = ALU_SEQ;
            default: r_alu_ctrl = ALU_NOP;
        endcase

        if (func == FN_MUL) begin
            r_mul = MUL_HILO;                        // 64-bit product split into hi/lo
        end
    end

endmodule

//--- rtl/control_pkg.sv
`include "control_defines.svh"

package control_pkg;

    typedef enum logic [1:0] {
        TYPE_R = 2'd0,
        TYPE_I = 2'd1,
        TYPE_J = 2'd2
    } instr_type_e;                                  // value 3 is not a legal type

    typedef enum logic [`FUNC_W-1:0] {
        FN_SLL  = 6'h00,
        FN_SRL  = 6'h02,
        FN_SRA  = 6'h03,
        FN_SLA  = 6'h04,
        FN_ADD  = 6'h20,
        FN_ADDU = 6'h21,
        FN_SUB  = 6'h22,
        FN_SUBU = 6'h23,
        FN_AND  = 6'h24,
        FN_OR   = 6'h25,
        FN_XOR  = 6'h26,
        FN_NOT  = 6'h27,
        FN_MUL  = 6'h28,
        FN_SLT  = 6'h2A,
        FN_SEQ  = 6'h2B
    } func_e;

    typedef enum logic [`OPCODE_W-1:0] {
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_ADDIU = 6'h09,
        OP_SLTI  = 6'h0A,
        OP_ANDI  = 6'h0C,
        OP_ORI   = 6'h0D,
        OP_XORI  = 6'h0E,
        OP_LUI   = 6'h0F,
        OP_BGE   = 6'h12,
        OP_BLT   = 6'h13,
        OP_BLE   = 6'h14,
        OP_BLEU  = 6'h15,
        OP_BGTU  = 6'h16,
        OP_BGT   = 6'h17,
        OP_MADD  = 6'h1C,
        OP_MADDU = 6'h1D,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2B
    } opcode_e;

    typedef enum logic [`ALU_CTRL_W-1:0] {
        ALU_AND   = 5'd0,
        ALU_OR    = 5'd1,
        ALU_ADD   = 5'd2,
        ALU_NOT   = 5'd3,
        ALU_XOR   = 5'd4,
        ALU_MUL   = 5'd5,
        ALU_SUB   = 5'd6,
        ALU_SLT   = 5'd7,
        ALU_ADDU  = 5'd8,
        ALU_SUBU  = 5'd9,
        ALU_SLEU  = 5'd10,
        ALU_SEQ   = 5'd11,
        ALU_SRA   = 5'd12,
        ALU_SLL   = 5'd13,
        ALU_SRL   = 5'd14,
        ALU_SLA   = 5'd15,
        ALU_SNE   = 5'd16,
        ALU_SGTU  = 5'd17,
        ALU_SGE   = 5'd18,
        ALU_SLE   = 5'd19,
        ALU_SGT   = 5'd20,
        ALU_MADDU = 5'd21,
        ALU_JUMP  = 5'd22,
        ALU_NOP   = 5'd30
    } alu_op_e;

    typedef enum logic [1:0] {
        MUL_NONE = 2'd0,
        MUL_HILO = 2'd1,                             // product to hi/lo
        MUL_ACC  = 2'd2                              // product added into hi/lo
    } mul_mode_e;

endpackage

//--- rtl/control_defines.svh
`ifndef CONTROL_DEFINES_SVH
`define CONTROL_DEFINES_SVH

// instruction field widths
`define OPCODE_W    6
`define FUNC_W      6
`define REG_ADDR_W  5
`define SHAMT_W     5

// operand and control widths
`define DATA_W      32
`define ALU_CTRL_W  5

// lui places the immediate in the upper half word
`define LUI_SHIFT   16

`endif
